/* hdl/heap_settings.svh */
// Array heap sizing
// Widths of array numbers, element indices and element data
`ifndef HEAP_SETTINGS_SVH
`define HEAP_SETTINGS_SVH

// --------------------
// Array numbering
// --------------------
`define HEAP_ARRAY_BITS 3   // Eight array slots

// --------------------
// Array contents
// --------------------
`define HEAP_INDEX_BITS 2   // Four elements per array
`define HEAP_DATA_BITS  12  // Element width in bits

`endif

/* hdl/heapPkg.sv */
// Array heap types
// Opcodes, error codes and the width-derived element types
package heapPkg;

  `include "heap_settings.svh"

  // --------------------
  // Command set
  // --------------------
  typedef enum logic [7:0] {
    opClear = 8'd1,   // Forget every array
    opWrite = 8'd2,   // Store one element
    opRead  = 8'd3,   // Fetch one element
    opSize  = 8'd4,   // Current length
    opPush  = 8'd14,  // Append at the end
    opPop   = 8'd15,  // Remove from the end
    opAlloc = 8'd18,  // Hand out a slot
    opFree  = 8'd19   // Return a slot
  } heapOp_t;

  typedef enum logic [3:0] {
    errNone = 4'd0, errNotAllocated, errFreed, errOutOfBounds, errFull, errEmpty, errOutOfMemory
  } heapErr_t;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId_t;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex_t; // Element position
  typedef logic [`HEAP_DATA_BITS-1:0]  elemData_t;  // Element value
  typedef logic [`HEAP_INDEX_BITS:0]   arrayLen_t;  // Length, 0 up to full

  localparam int arrayLength = 1 << `HEAP_INDEX_BITS; // Elements per array

endpackage

/* hdl/heapIfs.sv */
// Array heap internal buses
// allocIf links the controller to the slot allocator,
// storeIf links it to the element and length store

// --------------------
// Slot allocation
// --------------------
interface allocIf;
  logic               allocReq;       // Take granted slot
  logic               freeReq;        // Release queryId
  logic               clearReq;       // Drop all slots
  heapPkg::arrayId_t  queryId;        // Slot under test
  heapPkg::arrayId_t  granted;        // Next slot to hand out
  logic               exhausted;      // Nothing left
  logic               neverAllocated; // At or above high water
  logic               wasFreed;       // Below high water, not live

  modport ctrl (
    output allocReq, freeReq, clearReq, queryId,
    input  granted, exhausted, neverAllocated, wasFreed
  );

  modport alloc (
    input  allocReq, freeReq, clearReq, queryId,
    output granted, exhausted, neverAllocated, wasFreed
  );
endinterface

// --------------------
// Element and length store
// --------------------
interface storeIf;
  logic                 writeEn;     // Element write strobe
  logic                 lengthSet;   // Load newLength
  logic                 lengthClear; // Zero the length
  heapPkg::arrayId_t    arrayId;     // Addressed array
  heapPkg::elemIndex_t  elemIndex;   // Addressed element
  heapPkg::elemData_t   writeData;   // Element to store
  heapPkg::arrayLen_t   newLength;   // Length to load
  heapPkg::elemData_t   readData;    // Element at address
  heapPkg::arrayLen_t   curLength;   // Length of addressed array

  modport ctrl (
    output writeEn, lengthSet, lengthClear, arrayId, elemIndex, writeData, newLength,
    input  readData, curLength
  );

  modport store (
    input  writeEn, lengthSet, lengthClear, arrayId, elemIndex, writeData, newLength,
    output readData, curLength
  );
endinterface

/* hdl/heapAllocator.sv */
// Array slot allocator
// Recycles freed slots last in first out, otherwise hands out
// fresh slots from a high-water count; tracks which slots are live
`include "heap_settings.svh"

module heapAllocator (
  input logic  clock,
  input logic  resetN,
  allocIf.alloc bus
);

  localparam int slotCount = 1 << `HEAP_ARRAY_BITS;

  heapPkg::arrayId_t           freeStack [slotCount]; // Freed slots, top is newest
  logic [`HEAP_ARRAY_BITS:0]   stackTop;              // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0]   highWater;             // Slots ever handed out
  logic [slotCount-1:0]        live;                  // Slot currently in use
  heapPkg::arrayId_t           topSlot;               // Most recently freed
  logic                        stackEmpty;

  // --------------------
  // Status toward the controller
  // --------------------
  assign stackEmpty = (stackTop == '0);
  assign topSlot    = heapPkg::arrayId_t'(stackTop - 1'b1);

  assign bus.granted   = stackEmpty ? heapPkg::arrayId_t'(highWater) : freeStack[topSlot];
  assign bus.exhausted = stackEmpty && highWater[`HEAP_ARRAY_BITS]; // MSB set means all used

  assign bus.neverAllocated = ({1'b0, bus.queryId} >= highWater);
  assign bus.wasFreed       = !bus.neverAllocated && !live[bus.queryId];

  // --------------------
  // Counters and live flags
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop  <= '0;
      highWater <= '0;
      live      <= '0;
    end else if (bus.clearReq) begin
      stackTop  <= '0;                     // Forget freed slots
      highWater <= '0;
      live      <= '0;
    end else if (bus.allocReq) begin
      if (stackEmpty) begin
        highWater <= highWater + 1'b1;     // Fresh slot
      end else begin
        stackTop  <= stackTop - 1'b1;      // Reuse newest freed
      end
      live[bus.granted] <= 1'b1;
    end else if (bus.freeReq) begin
      stackTop          <= stackTop + 1'b1;
      live[bus.queryId] <= 1'b0;
    end
  end

  // Stack contents, only the pointer is reset
  always_ff @(posedge clock) begin
    if (bus.freeReq && !bus.clearReq) begin
      freeStack[heapPkg::arrayId_t'(stackTop)] <= bus.queryId;
    end
  end

endmodule

/* hdl/arrayStore.sv */
// Array element store
// One row of elements per array plus a length per array,
// read combinationally at the addressed array and index
`include "heap_settings.svh"

module arrayStore (
  input logic  clock,
  input logic  resetN,
  storeIf.store bus
);

  localparam int slotCount = 1 << `HEAP_ARRAY_BITS;

  heapPkg::elemData_t mem [slotCount][heapPkg::arrayLength]; // Element rows
  heapPkg::arrayLen_t lengths [slotCount];                   // Per-array length

  // --------------------
  // Read side
  // --------------------
  assign bus.readData  = mem[bus.arrayId][bus.elemIndex];
  assign bus.curLength = lengths[bus.arrayId];

  // --------------------
  // Element write
  // --------------------
  always_ff @(posedge clock) begin
    if (bus.writeEn) begin
      mem[bus.arrayId][bus.elemIndex] <= bus.writeData;
    end
  end

  // --------------------
  // Length update
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < slotCount; i++) begin
        lengths[i] <= '0;                         // All arrays empty
      end
    end else if (bus.lengthClear) begin
      lengths[bus.arrayId] <= '0;                 // Fresh allocation
    end else if (bus.lengthSet) begin
      lengths[bus.arrayId] <= bus.newLength;      // Grow or shrink
    end
  end

endmodule

/* hdl/heapController.sv */
// Array heap controller
// Wishbone classic slave that latches a command, checks it
// against allocator and store state, executes it and acknowledges
module heapController (
  input  logic                clock,
  input  logic                resetN,
  input  logic                cyc,
  input  logic                stb,
  input  heapPkg::heapOp_t    action,
  input  heapPkg::arrayId_t   array,
  input  heapPkg::elemIndex_t index,
  input  heapPkg::elemData_t  dataIn,
  output heapPkg::elemData_t  dataOut,
  output heapPkg::heapErr_t   error,
  output logic                ack,
  allocIf.ctrl                allocBus,
  storeIf.ctrl                storeBus
);

  typedef enum logic [1:0] {stIdle, stCheck, stExecute, stRespond} ctrlState_t;

  ctrlState_t          state;
  heapPkg::heapOp_t    cmdAction;  // Latched command
  heapPkg::arrayId_t   cmdArray;
  heapPkg::elemIndex_t cmdIndex;
  heapPkg::elemData_t  cmdData;
  heapPkg::heapErr_t   checkErr;   // Error found in check
  heapPkg::heapErr_t   cmdErr;     // Error held for the response
  heapPkg::elemData_t  resultNext; // Value formed in execute
  heapPkg::elemData_t  resultData;
  logic                doExec;     // Execute with no error
  logic                accept;

  assign accept = (state == stIdle) && cyc && stb && !ack;
  assign doExec = (state == stExecute) && (cmdErr == heapPkg::errNone);

  // --------------------
  // Addressing
  // --------------------
  assign allocBus.queryId = cmdArray;
  assign storeBus.arrayId = (cmdAction == heapPkg::opAlloc) ? allocBus.granted : cmdArray;
  assign storeBus.elemIndex =
      (cmdAction == heapPkg::opPush) ? heapPkg::elemIndex_t'(storeBus.curLength) :
      (cmdAction == heapPkg::opPop)  ? heapPkg::elemIndex_t'(storeBus.curLength - 1'b1) :
                                       cmdIndex;
  assign storeBus.writeData = cmdData;

  // --------------------
  // Command checks
  // --------------------
  always_comb begin
    checkErr = heapPkg::errNone;
    case (cmdAction)
      heapPkg::opAlloc: begin
        if (allocBus.exhausted) checkErr = heapPkg::errOutOfMemory;
      end
      heapPkg::opFree, heapPkg::opWrite, heapPkg::opRead,
      heapPkg::opSize, heapPkg::opPush, heapPkg::opPop: begin
        if (allocBus.neverAllocated) begin
          checkErr = heapPkg::errNotAllocated;
        end else if (allocBus.wasFreed) begin
          checkErr = heapPkg::errFreed;
        end else if (cmdAction == heapPkg::opRead && cmdIndex >= storeBus.curLength) begin
          checkErr = heapPkg::errOutOfBounds;    // Past current length
        end else if (cmdAction == heapPkg::opPush &&
                     storeBus.curLength == heapPkg::arrayLen_t'(heapPkg::arrayLength)) begin
          checkErr = heapPkg::errFull;
        end else if (cmdAction == heapPkg::opPop && storeBus.curLength == '0) begin
          checkErr = heapPkg::errEmpty;
        end
      end
      default: checkErr = heapPkg::errNone;    // Clear always passes
    endcase
  end

  // --------------------
  // Execute strobes and result
  // --------------------
  always_comb begin
    allocBus.allocReq    = 1'b0;
    allocBus.freeReq     = 1'b0;
    allocBus.clearReq    = 1'b0;
    storeBus.writeEn     = 1'b0;
    storeBus.lengthSet   = 1'b0;
    storeBus.lengthClear = 1'b0;
    storeBus.newLength   = storeBus.curLength;
    resultNext           = '0;                 // Zero unless a rule says otherwise
    if (doExec) begin
      case (cmdAction)
        heapPkg::opClear: allocBus.clearReq = 1'b1;
        heapPkg::opAlloc: begin
          allocBus.allocReq    = 1'b1;
          storeBus.lengthClear = 1'b1;         // New array starts empty
          resultNext           = heapPkg::elemData_t'(allocBus.granted);
        end
        heapPkg::opFree: allocBus.freeReq = 1'b1;
        heapPkg::opWrite: begin
          storeBus.writeEn = 1'b1;
          resultNext       = cmdData;
          if (cmdIndex >= storeBus.curLength) begin
            storeBus.lengthSet = 1'b1;         // Extend to index plus one
            storeBus.newLength = heapPkg::arrayLen_t'(cmdIndex) + 1'b1;
          end
        end
        heapPkg::opRead: resultNext = storeBus.readData;
        heapPkg::opSize: resultNext = heapPkg::elemData_t'(storeBus.curLength);
        heapPkg::opPush: begin
          storeBus.writeEn   = 1'b1;           // Store at current length
          storeBus.lengthSet = 1'b1;
          storeBus.newLength = storeBus.curLength + 1'b1;
        end
        heapPkg::opPop: begin
          storeBus.lengthSet = 1'b1;
          storeBus.newLength = storeBus.curLength - 1'b1;
          resultNext         = storeBus.readData; // Element below old length
        end
        default: resultNext = '0;
      endcase
    end
  end

  // --------------------
  // Sequencing FSM
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= stIdle;
      cmdErr  <= heapPkg::errNone;
      dataOut <= '0;
      error   <= heapPkg::errNone;
      ack     <= 1'b0;
    end else begin
      case (state)
        stIdle:    if (accept) state <= stCheck; // Edge 0
        stCheck: begin                           // Edge 1
          cmdErr <= checkErr;
          state  <= stExecute;
        end
        stExecute: state <= stRespond;           // Edge 2, strobes land here
        stRespond: begin
          if (!ack) begin                        // Edge 3
            ack     <= 1'b1;
            dataOut <= resultData;
            error   <= cmdErr;
          end else begin                         // Edge 4
            ack   <= 1'b0;
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Command and result payload
  always_ff @(posedge clock) begin
    if (accept) begin
      cmdAction <= action;
      cmdArray  <= array;
      cmdIndex  <= index;
      cmdData   <= dataIn;
    end
    if (state == stExecute) resultData <= resultNext;
  end

endmodule

/* hdl/heapTop.sv */
// Array heap top level
// Wishbone classic command port in front of the controller,
// slot allocator and array store
module heapTop (
  input  logic                clock,
  input  logic                resetN,
  input  logic                cyc,
  input  logic                stb,
  input  heapPkg::heapOp_t    action,
  input  heapPkg::arrayId_t   array,
  input  heapPkg::elemIndex_t index,
  input  heapPkg::elemData_t  dataIn,
  output heapPkg::elemData_t  dataOut,
  output heapPkg::heapErr_t   error,
  output logic                ack
);

  allocIf allocBus ();   // Controller to allocator
  storeIf storeBus ();   // Controller to store

  heapController ctrl0 (
    .clock    (clock),
    .resetN   (resetN),
    .cyc      (cyc),
    .stb      (stb),
    .action   (action),
    .array    (array),
    .index    (index),
    .dataIn   (dataIn),
    .dataOut  (dataOut),
    .error    (error),
    .ack      (ack),
    .allocBus (allocBus.ctrl),
    .storeBus (storeBus.ctrl)
  );

  heapAllocator alloc0 (
    .clock  (clock),
    .resetN (resetN),
    .bus    (allocBus.alloc)
  );

  arrayStore store0 (
    .clock  (clock),
    .resetN (resetN),
    .bus    (storeBus.store)
  );

endmodule

/* tests/heap_asserts.sv */
// Array heap handshake assertions
// Bound into the controller to watch ack against reset and requests
module heapAsserts (
  input logic              clock,
  input logic              resetN,
  input logic              cyc,
  input logic              stb,
  input logic              ack,
  input heapPkg::heapErr_t error,
  input heapPkg::heapOp_t  cmdAction  // Latched opcode
);
  timeunit 1ns;
  timeprecision 100ps;

  ackInReset: assert property (@(posedge clock) !resetN |-> !ack)
    else $error("ack high while reset is asserted");

  ackOneCycle: assert property (@(posedge clock) disable iff (!resetN) ack |=> !ack)
    else $error("ack held longer than one cycle");

  ackAfterRequest: assert property (@(posedge clock) disable iff (!resetN)
      ack |-> $past(cyc && stb))
    else $error("ack without a preceding request");

  clearNoError: assert property (@(posedge clock) disable iff (!resetN)
      (ack && cmdAction == heapPkg::opClear) |-> error == heapPkg::errNone)
    else $error("clear answered with an error code");

endmodule

bind heapController heapAsserts asserts0 (
  .clock     (clock),
  .resetN    (resetN),
  .cyc       (cyc),
  .stb       (stb),
  .ack       (ack),
  .error     (error),
  .cmdAction (cmdAction)
);

/* tests/heapTb.sv */
// Array heap testbench
// Directed and random Wishbone commands against a reference model
// of slot allocation and array contents, checked on every ack
`include "heap_settings.svh"

module heapTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int slotCount     = 1 << `HEAP_ARRAY_BITS;
  localparam int clockPeriod   = 4;
  localparam int resetCycles   = 16;
  localparam int directedMax   = 100;                       // Upper bound, directed part
  localparam int randomCount   = 400;
  localparam int commandBudget = directedMax + randomCount;
  localparam int timeLimit     = (commandBudget * 8 + resetCycles) * clockPeriod;

  logic                clock;
  logic                resetN;
  logic                cyc;
  logic                stb;
  heapPkg::heapOp_t    action;
  heapPkg::arrayId_t   array;
  heapPkg::elemIndex_t index;
  heapPkg::elemData_t  dataIn;
  heapPkg::elemData_t  dataOut;
  heapPkg::heapErr_t   error;
  logic                ack;

  // --------------------
  // Reference model state
  // --------------------
  int                 highWater;                              // Slots ever handed out
  heapPkg::arrayId_t  freeQ [$];                              // Back is newest freed
  bit [slotCount-1:0] live;
  int                 lengths [slotCount];
  heapPkg::elemData_t memModel [slotCount][heapPkg::arrayLength];

  heapPkg::elemData_t expDataQ [$];                           // Outstanding responses
  heapPkg::heapErr_t  expErrQ [$];
  string              nameQ [$];
  string              testName;
  int                 issuedCount;
  int                 checkedCount;

  heapTop dut0 (
    .clock   (clock),
    .resetN  (resetN),
    .cyc     (cyc),
    .stb     (stb),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .ack     (ack)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Expected response from the heap rules, then model update
  function automatic void refModel(input heapPkg::heapOp_t op, input heapPkg::arrayId_t id,
                                   input heapPkg::elemIndex_t idx,
                                   input heapPkg::elemData_t d,
                                   output heapPkg::elemData_t expData,
                                   output heapPkg::heapErr_t expErr);
    heapPkg::arrayId_t g;
    expData = '0;
    expErr  = heapPkg::errNone;
    if (op != heapPkg::opClear && op != heapPkg::opAlloc) begin
      if (int'(id) >= highWater) expErr = heapPkg::errNotAllocated;
      else if (!live[id]) expErr = heapPkg::errFreed;       // Handed out, now gone
    end
    if (expErr == heapPkg::errNone) begin
      case (op)
        heapPkg::opClear: begin
          freeQ.delete();
          highWater = 0;
          live      = '0;
        end
        heapPkg::opAlloc: begin
          if (freeQ.size() == 0 && highWater == slotCount) begin
            expErr = heapPkg::errOutOfMemory;
          end else begin
            if (freeQ.size() > 0) begin
              g = freeQ.pop_back();                          // Newest freed first
            end else begin
              g = heapPkg::arrayId_t'(highWater);
              highWater++;
            end
            live[g]    = 1'b1;
            lengths[g] = 0;
            expData    = heapPkg::elemData_t'(g);
          end
        end
        heapPkg::opFree: begin
          freeQ.push_back(id);
          live[id] = 1'b0;
        end
        heapPkg::opWrite: begin
          memModel[id][idx] = d;
          if (int'(idx) >= lengths[id]) lengths[id] = int'(idx) + 1;
          expData = d;
        end
        heapPkg::opRead: begin
          if (int'(idx) >= lengths[id]) expErr = heapPkg::errOutOfBounds;
          else expData = memModel[id][idx];
        end
        heapPkg::opSize: expData = heapPkg::elemData_t'(lengths[id]);
        heapPkg::opPush: begin
          if (lengths[id] == heapPkg::arrayLength) begin
            expErr = heapPkg::errFull;
          end else begin
            memModel[id][heapPkg::elemIndex_t'(lengths[id])] = d;
            lengths[id]++;
          end
        end
        heapPkg::opPop: begin
          if (lengths[id] == 0) begin
            expErr = heapPkg::errEmpty;
          end else begin
            lengths[id]--;
            expData = memModel[id][heapPkg::elemIndex_t'(lengths[id])];
          end
        end
        default: expErr = heapPkg::errNone;
      endcase
    end
  endfunction

  // One Wishbone request, held until ack, with latency check
  task automatic issue(input heapPkg::heapOp_t op, input heapPkg::arrayId_t id,
                       input heapPkg::elemIndex_t idx, input heapPkg::elemData_t d);
    int                 cycles;
    heapPkg::elemData_t expData;
    heapPkg::heapErr_t  expErr;
    refModel(op, id, idx, d, expData, expErr);
    expDataQ.push_back(expData);
    expErrQ.push_back(expErr);
    nameQ.push_back(testName);
    issuedCount++;
    @(negedge clock);
    cyc    = 1'b1;
    stb    = 1'b1;
    action = op;
    array  = id;
    index  = idx;
    dataIn = d;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!ack);
    cyc = 1'b0;                                              // Drop after ack
    stb = 1'b0;
    check({testName, " latency"}, 32'd3, 32'(cycles - 1));   // Accept edge to ack edge
  endtask

  // --------------------
  // Response compare
  // --------------------
  initial begin
    string              name;
    heapPkg::elemData_t expData;
    heapPkg::heapErr_t  expErr;
    forever begin
      @(negedge clock);
      if (ack) begin
        if (expDataQ.size() == 0) begin
          $display("ack arrived with no command outstanding");
          $display("Checks failed");
          $fatal(1, "Unexpected ack");
        end else begin
          name    = nameQ.pop_front();
          expData = expDataQ.pop_front();
          expErr  = expErrQ.pop_front();
          check({name, " dataOut"}, 32'(expData), 32'(dataOut));
          check({name, " error"}, 32'(expErr), 32'(error));
          checkedCount++;
        end
      end
    end
  end

  initial begin
    #(timeLimit);
    $display("Run hung: commands did not finish within the cycle budget");
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int               pick;
    heapPkg::heapOp_t op;
    void'($urandom(32'hb933_aaa0));
    resetN       = 1'b0;
    cyc          = 1'b0;
    stb          = 1'b0;
    action       = heapPkg::opClear;
    array        = '0;
    index        = '0;
    dataIn       = '0;
    highWater    = 0;
    live         = '0;
    issuedCount  = 0;
    checkedCount = 0;
    testName     = "reset";
    repeat (resetCycles) @(negedge clock);
    resetN = 1'b1;

    testName = "allocSweep";                                 // Ascending slots, then full
    issue(heapPkg::opClear, '0, '0, '0);
    for (int i = 0; i <= slotCount; i++) issue(heapPkg::opAlloc, '0, '0, '0);
    testName = "memoryFill";                                 // Every element known
    for (int s = 0; s < slotCount; s++) begin
      for (int e = 0; e < heapPkg::arrayLength; e++) begin
        issue(heapPkg::opWrite, heapPkg::arrayId_t'(s), heapPkg::elemIndex_t'(e),
              heapPkg::elemData_t'($urandom));
      end
    end

    testName = "freeReuse";
    issue(heapPkg::opFree, 3'd2, '0, '0);
    issue(heapPkg::opFree, 3'd5, '0, '0);
    issue(heapPkg::opAlloc, '0, '0, '0);                     // Gets 5 back
    issue(heapPkg::opAlloc, '0, '0, '0);                     // Then 2
    issue(heapPkg::opFree, 3'd3, '0, '0);
    issue(heapPkg::opFree, 3'd3, '0, '0);                    // Double free
    issue(heapPkg::opRead, 3'd3, '0, '0);
    issue(heapPkg::opClear, '0, '0, '0);
    issue(heapPkg::opAlloc, '0, '0, '0);
    issue(heapPkg::opAlloc, '0, '0, '0);
    issue(heapPkg::opRead, 3'd4, '0, '0);                    // Above high water
    issue(heapPkg::opSize, 3'd6, '0, '0);

    testName = "writeRead";
    issue(heapPkg::opSize, 3'd0, '0, '0);
    issue(heapPkg::opWrite, 3'd0, 2'd2, 12'h5a3);            // Length becomes 3
    issue(heapPkg::opSize, 3'd0, '0, '0);
    issue(heapPkg::opRead, 3'd0, 2'd2, '0);
    issue(heapPkg::opRead, 3'd0, 2'd3, '0);                  // Past length
    issue(heapPkg::opWrite, 3'd0, 2'd0, 12'hc0f);
    issue(heapPkg::opSize, 3'd0, '0, '0);
    issue(heapPkg::opRead, 3'd0, 2'd0, '0);
    issue(heapPkg::opRead, 3'd0, 2'd1, '0);

    testName = "pushPop";
    issue(heapPkg::opPop, 3'd1, '0, '0);                     // Empty
    for (int i = 0; i <= heapPkg::arrayLength; i++) begin
      issue(heapPkg::opPush, 3'd1, '0, heapPkg::elemData_t'($urandom));
    end
    issue(heapPkg::opSize, 3'd1, '0, '0);
    for (int i = 0; i <= heapPkg::arrayLength; i++) issue(heapPkg::opPop, 3'd1, '0, '0);

    testName = "randomMix";
    for (int n = 0; n < randomCount; n++) begin
      pick = $urandom_range(39, 0);
      if (pick == 0) op = heapPkg::opClear;                   // Rare
      else if (pick < 6) op = heapPkg::opAlloc;
      else if (pick < 10) op = heapPkg::opFree;
      else if (pick < 17) op = heapPkg::opWrite;
      else if (pick < 24) op = heapPkg::opRead;
      else if (pick < 28) op = heapPkg::opSize;
      else if (pick < 34) op = heapPkg::opPush;
      else op = heapPkg::opPop;
      issue(op, heapPkg::arrayId_t'($urandom_range(slotCount - 1, 0)),
            heapPkg::elemIndex_t'($urandom_range(heapPkg::arrayLength - 1, 0)),
            heapPkg::elemData_t'($urandom));
    end

    wait (checkedCount == issuedCount);                      // Last response compared
    @(negedge clock);
    $display("All checks passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hdl
hdl/heapPkg.sv
hdl/heapIfs.sv
hdl/heapAllocator.sv
hdl/arrayStore.sv
hdl/heapController.sv
hdl/heapTop.sv
tests/heap_asserts.sv
tests/heapTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the array heap testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module heapTb -f filelist.f -o heapSim \
  && ./obj_dir/heapSim \
  || { echo "Simulation failed"; exit 1; }
